// File: dv/sm83_lite_tb.sv
`timescale 1ns/1ps

module sm83_lite_tb;

  localparam int RESET_CYCLES = 3;
  localparam int NUM_TESTS = 6;
  // Each program ends well inside this many clocks
  localparam int TEST_BUDGET = 400;
  localparam int CYCLE_LIMIT = NUM_TESTS * TEST_BUDGET + 600;
  // A store here marks the end of a program
  localparam cpu_pkg::addr_t DONE_ADDR = 16'hFFF0;

  logic           clk;
  logic           reset;
  cpu_pkg::byte_t rdata;
  cpu_pkg::addr_t addr;
  cpu_pkg::byte_t wdata;
  logic           read_en;
  logic           write_en;
  logic           instr_boundary;

  // Bus memory and the image copied into it during reset
  bit [7:0] mem [0:65535];
  bit [7:0] img [0:65535];
  logic     load_req;

  cpu_pkg::addr_t cursor;
  int clk_count;
  int errors;
  int checks;
  int tests_run;
  int err_mark;

  bit read_prev;
  bit write_prev;
  int done_count;
  cpu_pkg::addr_t read_q[$];
  cpu_pkg::addr_t wr_addr_q[$];
  cpu_pkg::byte_t wr_data_q[$];
  int bnd_q[$];

  int read_base;
  int write_base;
  int bnd_base;
  int done_base;

  sm83_lite_top dut_i (
    .clk            (clk),
    .reset          (reset),
    .rdata          (rdata),
    .addr           (addr),
    .wdata          (wdata),
    .read_en        (read_en),
    .write_en       (write_en),
    .instr_boundary (instr_boundary)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  assign rdata = mem[addr];

  always @(posedge clk) begin
    if (load_req) begin
      for (int i = 0; i < 65536; i++) begin
        mem[i[15:0]] <= img[i[15:0]];
      end
    end else if (write_en) begin
      mem[addr] <= wdata;
    end
  end

  // Bus monitor keeps one entry per strobe
  always @(negedge clk) begin
    read_prev <= read_en;
    write_prev <= write_en;
    if (read_en && !read_prev) begin
      read_q.push_back(addr);
    end
    if (write_en && !write_prev) begin
      if (addr == DONE_ADDR) begin
        done_count <= done_count + 1;
      end else begin
        wr_addr_q.push_back(addr);
        wr_data_q.push_back(wdata);
        $display("write %h <- %h at %0t", addr, wdata, $time);
      end
    end
    if (instr_boundary) begin
      bnd_q.push_back(clk_count);
    end
  end

  always @(posedge clk) begin
    clk_count <= clk_count + 1;
    if (clk_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d clock cycles, a program never reached its end", clk_count);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(input cpu_pkg::byte_t got, input cpu_pkg::byte_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input cpu_pkg::addr_t got, input cpu_pkg::addr_t exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Fill depends on the whole address so stray fetches show up
  task automatic clear_image();
    for (int i = 0; i < 65536; i++) begin
      img[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'h5A;
    end
    cursor = 16'h0000;
  endtask

  task automatic set_origin(input cpu_pkg::addr_t at);
    cursor = at;
  endtask

  task automatic op1(input cpu_pkg::byte_t b0);
    img[cursor] = b0;
    cursor = cursor + 16'd1;
  endtask

  task automatic op2(input cpu_pkg::byte_t b0, input cpu_pkg::byte_t b1);
    op1(b0);
    op1(b1);
  endtask

  task automatic op3(input cpu_pkg::byte_t b0, input cpu_pkg::byte_t b1,
                     input cpu_pkg::byte_t b2);
    op1(b0);
    op2(b1, b2);
  endtask

  // End marker store followed by a JP to itself
  task automatic emit_end();
    cpu_pkg::addr_t here;
    op3(8'h21, DONE_ADDR[7:0], DONE_ADDR[15:8]);
    op1(8'h77);
    here = cursor;
    op3(8'hC3, here[7:0], here[15:8]);
  endtask

  task automatic reset_and_load();
    err_mark = errors;
    @(posedge clk);
    reset <= 1'b1;
    load_req <= 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_bit(read_en, 1'b0, "read_en in reset");
      check_bit(write_en, 1'b0, "write_en in reset");
      check_bit(instr_boundary, 1'b0, "instr_boundary in reset");
      @(posedge clk);
      load_req <= 1'b0;
    end
    reset <= 1'b0;
    read_base = read_q.size();
    write_base = wr_addr_q.size();
    bnd_base = bnd_q.size();
    done_base = done_count;
  endtask

  task automatic run_to_done();
    while (done_count == done_base) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic check_writes(input cpu_pkg::addr_t exp_addr[$],
                              input cpu_pkg::byte_t exp_data[$]);
    check_count(wr_addr_q.size() - write_base, exp_addr.size(), "number of bus writes");
    for (int k = 0; k < exp_addr.size(); k++) begin
      if (write_base + k < wr_addr_q.size()) begin
        check_addr(wr_addr_q[write_base + k], exp_addr[k], "write address");
        check_byte(wr_data_q[write_base + k], exp_data[k], "write data");
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err_mark);
    end
  endtask

  task automatic reset_behavior();
    cpu_pkg::addr_t exp_addr[$];
    cpu_pkg::byte_t exp_data[$];
    clear_image();
    op2(8'h3E, 8'h42);
    emit_end();
    reset_and_load();
    run_to_done();
    if (read_q.size() > read_base) begin
      check_addr(read_q[read_base], 16'h0000, "first read address");
    end else begin
      errors++;
      $display("No read strobe was seen after reset");
    end
    check_writes(exp_addr, exp_data);
    end_test("reset");
  endtask

  task automatic load_and_store();
    cpu_pkg::addr_t exp_addr[$];
    cpu_pkg::byte_t exp_data[$];
    clear_image();
    img[16'h8001] = 8'h5C;
    op2(8'h3E, 8'h37);
    op3(8'h21, 8'h00, 8'h80);
    op1(8'h77);
    op2(8'h2E, 8'h01);
    op1(8'h7E);
    op2(8'h26, 8'h81);
    op2(8'h2E, 8'h02);
    op1(8'h77);
    emit_end();
    exp_addr.push_back(16'h8000);
    exp_data.push_back(8'h37);
    exp_addr.push_back(16'h8102);
    exp_data.push_back(8'h5C);
    reset_and_load();
    run_to_done();
    check_writes(exp_addr, exp_data);
    end_test("load_store");
  endtask

  task automatic alu_stores();
    cpu_pkg::addr_t exp_addr[$];
    cpu_pkg::byte_t exp_data[$];
    cpu_pkg::byte_t a_val;
    cpu_pkg::byte_t b_val;
    a_val = 8'hF0;
    b_val = 8'h25;
    clear_image();
    op3(8'h21, 8'h00, 8'h90);
    op2(8'h3E, a_val);
    op2(8'h06, b_val);
    op1(8'h80);
    op1(8'h77);
    op2(8'h2E, 8'h01);
    op1(8'h90);
    op1(8'h77);
    op2(8'h2E, 8'h02);
    op1(8'hA0);
    op1(8'h77);
    op2(8'h2E, 8'h03);
    op1(8'h3C);
    op1(8'h77);
    op2(8'h2E, 8'h04);
    op1(8'hAF);
    op1(8'h77);
    op2(8'h3E, 8'hFF);
    op1(8'h3C);
    op2(8'h2E, 8'h05);
    op1(8'h77);
    emit_end();
    // Expected stores wrap at 8 bits
    a_val = a_val + b_val;
    exp_data.push_back(a_val);
    a_val = a_val - b_val;
    exp_data.push_back(a_val);
    a_val = a_val & b_val;
    exp_data.push_back(a_val);
    a_val = a_val + 8'd1;
    exp_data.push_back(a_val);
    a_val = a_val ^ a_val;
    exp_data.push_back(a_val);
    a_val = 8'hFF;
    a_val = a_val + 8'd1;
    exp_data.push_back(a_val);
    for (int k = 0; k < 6; k++) begin
      exp_addr.push_back(16'h9000 + k[15:0]);
    end
    reset_and_load();
    run_to_done();
    check_writes(exp_addr, exp_data);
    end_test("alu");
  endtask

  task automatic plain_jump();
    cpu_pkg::addr_t exp_addr[$];
    cpu_pkg::byte_t exp_data[$];
    int idx;
    clear_image();
    op3(8'h21, 8'h00, 8'hA0);
    op2(8'h3E, 8'h5A);
    op3(8'hC3, 8'h40, 8'h00);
    // Trap if the jump falls through
    op2(8'h3E, 8'h99);
    op1(8'h77);
    set_origin(16'h0040);
    op2(8'h3E, 8'hA5);
    op1(8'h77);
    emit_end();
    exp_addr.push_back(16'hA000);
    exp_data.push_back(8'hA5);
    reset_and_load();
    run_to_done();
    idx = -1;
    for (int k = read_q.size() - 1; k >= read_base; k--) begin
      if (read_q[k] == 16'h0006) begin
        idx = k;
      end
    end
    if (idx >= 0 && idx + 2 < read_q.size()) begin
      check_addr(read_q[idx + 1], 16'h0007, "second JP operand read");
      check_addr(read_q[idx + 2], 16'h0040, "opcode read after JP");
    end else begin
      errors++;
      $display("The JP operand reads were not seen on the bus");
    end
    check_writes(exp_addr, exp_data);
    end_test("jump");
  endtask

  task automatic cond_jumps();
    cpu_pkg::addr_t exp_addr[$];
    cpu_pkg::byte_t exp_data[$];
    clear_image();
    op3(8'h21, 8'h00, 8'hB0);
    op2(8'h3E, 8'h07);
    op1(8'hAF);
    op3(8'hC2, 8'h30, 8'h00);
    op2(8'h3E, 8'h11);
    op1(8'h77);
    op3(8'hCA, 8'h20, 8'h00);
    op2(8'h3E, 8'h77);
    op1(8'h77);
    set_origin(16'h0020);
    op2(8'h3E, 8'h22);
    op2(8'h2E, 8'h01);
    op1(8'h77);
    op1(8'h3C);
    op3(8'hC2, 8'h40, 8'h00);
    op2(8'h3E, 8'h66);
    op1(8'h77);
    set_origin(16'h0030);
    op2(8'h3E, 8'h99);
    op1(8'h77);
    set_origin(16'h0040);
    op2(8'h3E, 8'h33);
    op2(8'h2E, 8'h02);
    op1(8'h77);
    emit_end();
    exp_addr.push_back(16'hB000);
    exp_data.push_back(8'h11);
    exp_addr.push_back(16'hB001);
    exp_data.push_back(8'h22);
    exp_addr.push_back(16'hB002);
    exp_data.push_back(8'h33);
    reset_and_load();
    run_to_done();
    check_writes(exp_addr, exp_data);
    end_test("cond_jump");
  endtask

  task automatic boundary_gaps();
    cpu_pkg::addr_t exp_addr[$];
    cpu_pkg::byte_t exp_data[$];
    // NOP, LD A, LD HL, store, load, INC, JP Z no, JP NZ yes, JP, LD B, ADD
    int exp_cycles[11] = '{1, 2, 3, 2, 2, 1, 3, 4, 4, 2, 1};
    clear_image();
    op1(8'h00);
    op2(8'h3E, 8'h00);
    op3(8'h21, 8'h00, 8'hC0);
    op1(8'h77);
    op1(8'h7E);
    op1(8'h3C);
    op3(8'hCA, 8'h30, 8'h00);
    op3(8'hC2, 8'h10, 8'h00);
    set_origin(16'h0010);
    op3(8'hC3, 8'h13, 8'h00);
    op2(8'h06, 8'h01);
    op1(8'h80);
    emit_end();
    set_origin(16'h0030);
    op2(8'h3E, 8'h99);
    op1(8'h77);
    exp_addr.push_back(16'hC000);
    exp_data.push_back(8'h00);
    reset_and_load();
    run_to_done();
    if (bnd_q.size() - bnd_base < 12) begin
      errors++;
      $display("Too few instruction boundaries, saw %0d", bnd_q.size() - bnd_base);
    end else begin
      for (int k = 0; k < 11; k++) begin
        check_count(bnd_q[bnd_base + k + 1] - bnd_q[bnd_base + k], 4 * exp_cycles[k],
                    $sformatf("clocks in instruction %0d", k));
      end
    end
    check_writes(exp_addr, exp_data);
    end_test("timing");
  endtask

  initial begin
    reset <= 1'b1;
    load_req <= 1'b0;
    reset_behavior();
    load_and_store();
    alu_stores();
    plain_jump();
    cond_jumps();
    boundary_gaps();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: logic/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
  input  cpu_pkg::alu_op_t op,
  input  cpu_pkg::byte_t   x,
  input  cpu_pkg::byte_t   y,
  input  cpu_pkg::byte_t   flags_in,
  output cpu_pkg::byte_t   result,
  output cpu_pkg::byte_t   flags_out
);

  // Ninth bit holds the carry or borrow
  logic [8:0] wide;
  logic [4:0] nibble;
  logic       flag_n;
  logic       flag_h;
  logic       flag_c;

  always_comb begin
    wide   = {1'b0, x};
    nibble = {1'b0, x[3:0]};
    flag_n = 1'b0;
    flag_h = 1'b0;
    flag_c = flags_in[cpu_pkg::FLAG_C];

    case (op)
      cpu_pkg::ALU_ADD: begin
        wide   = {1'b0, x} + {1'b0, y};
        nibble = {1'b0, x[3:0]} + {1'b0, y[3:0]};
        flag_h = nibble[4];
        flag_c = wide[8];
      end
      cpu_pkg::ALU_SUB: begin
        wide   = {1'b0, x} - {1'b0, y};
        nibble = {1'b0, x[3:0]} - {1'b0, y[3:0]};
        flag_n = 1'b1;
        flag_h = nibble[4];
        flag_c = wide[8];
      end
      cpu_pkg::ALU_AND: begin
        wide   = {1'b0, x & y};
        flag_h = 1'b1;
        flag_c = 1'b0;
      end
      cpu_pkg::ALU_XOR: begin
        wide   = {1'b0, x ^ y};
        flag_c = 1'b0;
      end
      cpu_pkg::ALU_INC: begin
        // Carry is left alone
        wide   = {1'b0, x} + 9'd1;
        nibble = {1'b0, x[3:0]} + 5'd1;
        flag_h = nibble[4];
      end
      default: ;
    endcase

    result = wide[7:0];

    if (op == cpu_pkg::ALU_NONE) begin
      flags_out = flags_in;
    end else begin
      flags_out = '0;
      flags_out[cpu_pkg::FLAG_Z] = (wide[7:0] == 8'h00);
      flags_out[cpu_pkg::FLAG_N] = flag_n;
      flags_out[cpu_pkg::FLAG_H] = flag_h;
      flags_out[cpu_pkg::FLAG_C] = flag_c;
    end
  end

endmodule

// File: logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
  parameter cpu_pkg::addr_t RESET_VECTOR = cpu_pkg::RESET_PC
) (
  input  logic           clk,
  input  logic           reset,
  input  cpu_pkg::byte_t rdata,
  output cpu_pkg::addr_t addr,
  output cpu_pkg::byte_t wdata,
  output logic           read_en,
  output logic           write_en,
  output logic           instr_boundary
);

  cpu_pkg::t_phase_t      t_phase;
  cpu_pkg::cycle_count_t  cycle_count;
  cpu_pkg::control_word_t control_word;
  cpu_pkg::control_word_t rom_word;
  cpu_pkg::cycle_word_t   cur;

  cpu_pkg::addr_t    addr_val;
  cpu_pkg::idu_op_t  idu_cmd;
  cpu_pkg::reg_sel_t wr_sel;
  cpu_pkg::byte_t    wr_data;
  logic              flags_we;
  logic              jump;

  cpu_pkg::byte_t a;
  cpu_pkg::byte_t b;
  cpu_pkg::byte_t h;
  cpu_pkg::byte_t l;
  cpu_pkg::byte_t w;
  cpu_pkg::byte_t z;
  cpu_pkg::byte_t flags;
  cpu_pkg::byte_t ir;

  cpu_pkg::byte_t alu_y;
  cpu_pkg::byte_t alu_result;
  cpu_pkg::byte_t alu_flags;
  logic           cond_fail;

  assign cur = control_word.cycles[cycle_count];

  microcode_rom rom_i (
    .opcode       (ir),
    .control_word (rom_word)
  );

  cpu_regs #(
    .RESET_VECTOR (RESET_VECTOR)
  ) regs_i (
    .clk      (clk),
    .reset    (reset),
    .addr_sel (cur.addr_src),
    .idu_op   (idu_cmd),
    .wr_sel   (wr_sel),
    .wr_data  (wr_data),
    .flags_we (flags_we),
    .flags_in (alu_flags),
    .jump     (jump),
    .addr_val (addr_val),
    .a        (a),
    .b        (b),
    .h        (h),
    .l        (l),
    .w        (w),
    .z        (z),
    .flags    (flags),
    .ir       (ir),
    .pc       ()
  );

  cpu_alu alu_i (
    .op        (cur.alu_op),
    .x         (a),
    .y         (alu_y),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  function automatic cpu_pkg::byte_t pick_byte(input cpu_pkg::reg_sel_t sel);
    case (sel)
      cpu_pkg::REG_B: return b;
      cpu_pkg::REG_H: return h;
      cpu_pkg::REG_L: return l;
      cpu_pkg::REG_W: return w;
      cpu_pkg::REG_Z: return z;
      default:        return a;
    endcase
  endfunction

  always_comb begin
    alu_y = pick_byte(cur.alu_src);
  end

  // Read data lands in T3 while the IDU, ALU and jump act in T4
  always_comb begin
    wr_sel   = cpu_pkg::REG_NONE;
    wr_data  = rdata;
    flags_we = 1'b0;
    idu_cmd  = cpu_pkg::IDU_NONE;
    jump     = 1'b0;
    if (t_phase == cpu_pkg::T3 && cur.bus_op == cpu_pkg::BUS_READ) begin
      wr_sel = cur.bus_reg;
    end
    if (t_phase == cpu_pkg::T4) begin
      idu_cmd = cur.idu_op;
      jump    = (cur.misc_op == cpu_pkg::MISC_JUMP_WZ);
      if (cur.alu_op != cpu_pkg::ALU_NONE) begin
        wr_sel   = cpu_pkg::REG_A;
        wr_data  = alu_result;
        flags_we = 1'b1;
      end
    end
  end

  always_comb begin
    cond_fail = 1'b0;
    if (cur.misc_op == cpu_pkg::MISC_COND_CHECK) begin
      if (cur.cond == cpu_pkg::COND_Z) begin
        cond_fail = !flags[cpu_pkg::FLAG_Z];
      end else begin
        cond_fail = flags[cpu_pkg::FLAG_Z];
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      t_phase        <= cpu_pkg::T1;
      cycle_count    <= '0;
      control_word   <= cpu_pkg::CW_NOP;
      addr           <= RESET_VECTOR;
      wdata          <= '0;
      read_en        <= 1'b0;
      write_en       <= 1'b0;
      instr_boundary <= 1'b0;
    end else begin
      instr_boundary <= 1'b0;
      case (t_phase)
        cpu_pkg::T1: begin
          addr    <= addr_val;
          t_phase <= cpu_pkg::T2;
        end
        cpu_pkg::T2: begin
          read_en  <= (cur.bus_op == cpu_pkg::BUS_READ);
          write_en <= (cur.bus_op == cpu_pkg::BUS_WRITE);
          if (cur.bus_op == cpu_pkg::BUS_WRITE) begin
            wdata <= pick_byte(cur.bus_reg);
          end
          t_phase <= cpu_pkg::T3;
        end
        cpu_pkg::T3: begin
          t_phase <= cpu_pkg::T4;
        end
        default: begin
          read_en  <= 1'b0;
          write_en <= 1'b0;
          if (cond_fail) begin
            // Skip straight to the fetch cycle
            cycle_count <= control_word.num_cycles - 3'd1;
          end else if (cycle_count + 3'd1 >= control_word.num_cycles) begin
            // IR was loaded in T3 so the ROM already shows the next opcode
            cycle_count    <= '0;
            control_word   <= rom_word;
            instr_boundary <= 1'b1;
          end else begin
            cycle_count <= cycle_count + 3'd1;
          end
          t_phase <= cpu_pkg::T1;
        end
      endcase
    end
  end

  a_no_dual_enable: assert property (@(posedge clk) disable iff (reset)
    !(read_en && write_en));

  a_enable_phase: assert property (@(posedge clk) disable iff (reset)
    (t_phase == cpu_pkg::T1 || t_phase == cpu_pkg::T2) |-> !(read_en || write_en));

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [15:0] addr_t;

  // Clock phase within a machine cycle
  typedef enum logic [1:0] {
    T1,
    T2,
    T3,
    T4
  } t_phase_t;

  typedef logic [2:0] cycle_count_t;

  localparam int MAX_CYCLES_PER_INSTR = 5;

  typedef enum logic [1:0] {
    ADDR_PC,
    ADDR_HL,
    ADDR_WZ,
    ADDR_NONE
  } addr_src_t;

  typedef enum logic {
    IDU_NONE,
    IDU_INC
  } idu_op_t;

  typedef enum logic [1:0] {
    BUS_NONE,
    BUS_READ,
    BUS_WRITE
  } bus_op_t;

  // Byte destination of a read, byte source of a write
  typedef enum logic [3:0] {
    REG_A,
    REG_B,
    REG_C,
    REG_H,
    REG_L,
    REG_W,
    REG_Z,
    REG_IR,
    REG_NONE
  } reg_sel_t;

  typedef enum logic [2:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_XOR,
    ALU_INC
  } alu_op_t;

  typedef enum logic [1:0] {
    MISC_NONE,
    MISC_COND_CHECK,
    MISC_JUMP_WZ
  } misc_op_t;

  typedef enum logic {
    COND_NZ,
    COND_Z
  } cond_t;

  // One machine cycle of an instruction, ALU result always goes to A
  typedef struct packed {
    addr_src_t addr_src;
    idu_op_t   idu_op;
    bus_op_t   bus_op;
    reg_sel_t  bus_reg;
    alu_op_t   alu_op;
    reg_sel_t  alu_src;
    misc_op_t  misc_op;
    cond_t     cond;
  } cycle_word_t;

  typedef struct packed {
    cycle_count_t num_cycles;
    cycle_word_t [MAX_CYCLES_PER_INSTR-1:0] cycles;
  } control_word_t;

  localparam int FLAG_Z = 7;
  localparam int FLAG_N = 6;
  localparam int FLAG_H = 5;
  localparam int FLAG_C = 4;

  localparam addr_t RESET_PC = 16'h0000;
  localparam addr_t RESET_SP = 16'hFFFE;

  localparam cycle_word_t CYCLE_IDLE = '{
      addr_src: ADDR_NONE, idu_op: IDU_NONE, bus_op: BUS_NONE, bus_reg: REG_NONE,
      alu_op: ALU_NONE, alu_src: REG_NONE, misc_op: MISC_NONE, cond: COND_NZ};

  // Opcode fetch that closes every instruction
  localparam cycle_word_t CYCLE_FETCH = '{
      addr_src: ADDR_PC, idu_op: IDU_INC, bus_op: BUS_READ, bus_reg: REG_IR,
      alu_op: ALU_NONE, alu_src: REG_NONE, misc_op: MISC_NONE, cond: COND_NZ};

  localparam control_word_t CW_NOP = '{
      num_cycles: 3'd1,
      cycles: '{CYCLE_IDLE, CYCLE_IDLE, CYCLE_IDLE, CYCLE_IDLE, CYCLE_FETCH}};

endpackage

// File: logic/cpu_regs.sv
`timescale 1ns/1ps

module cpu_regs #(
  parameter cpu_pkg::addr_t RESET_VECTOR = cpu_pkg::RESET_PC
) (
  input  logic                clk,
  input  logic                reset,
  input  cpu_pkg::addr_src_t  addr_sel,
  input  cpu_pkg::idu_op_t    idu_op,
  input  cpu_pkg::reg_sel_t   wr_sel,
  input  cpu_pkg::byte_t      wr_data,
  input  logic                flags_we,
  input  cpu_pkg::byte_t      flags_in,
  input  logic                jump,
  output cpu_pkg::addr_t      addr_val,
  output cpu_pkg::byte_t      a,
  output cpu_pkg::byte_t      b,
  output cpu_pkg::byte_t      h,
  output cpu_pkg::byte_t      l,
  output cpu_pkg::byte_t      w,
  output cpu_pkg::byte_t      z,
  output cpu_pkg::byte_t      flags,
  output cpu_pkg::byte_t      ir,
  output cpu_pkg::addr_t      pc
);

  cpu_pkg::byte_t c;
  cpu_pkg::addr_t sp;
  cpu_pkg::addr_t addr_inc;

  always_comb begin
    case (addr_sel)
      cpu_pkg::ADDR_PC: addr_val = pc;
      cpu_pkg::ADDR_HL: addr_val = {h, l};
      cpu_pkg::ADDR_WZ: addr_val = {w, z};
      // Idle cycles park the address lines on SP
      default:          addr_val = sp;
    endcase
  end

  // IDU works on whatever pair is on the address bus
  assign addr_inc = addr_val + 16'd1;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      a     <= '0;
      b     <= '0;
      c     <= '0;
      h     <= '0;
      l     <= '0;
      w     <= '0;
      z     <= '0;
      flags <= '0;
      ir    <= '0;
      pc    <= RESET_VECTOR;
      sp    <= cpu_pkg::RESET_SP;
    end else begin
      if (idu_op == cpu_pkg::IDU_INC) begin
        case (addr_sel)
          cpu_pkg::ADDR_PC: pc <= addr_inc;
          cpu_pkg::ADDR_HL: {h, l} <= addr_inc;
          cpu_pkg::ADDR_WZ: {w, z} <= addr_inc;
          default: ;
        endcase
      end

      if (jump) begin
        pc <= {w, z};
      end

      // Low nibble of F always reads as zero
      if (flags_we) begin
        flags <= {flags_in[7:4], 4'h0};
      end

      case (wr_sel)
        cpu_pkg::REG_A:  a  <= wr_data;
        cpu_pkg::REG_B:  b  <= wr_data;
        cpu_pkg::REG_C:  c  <= wr_data;
        cpu_pkg::REG_H:  h  <= wr_data;
        cpu_pkg::REG_L:  l  <= wr_data;
        cpu_pkg::REG_W:  w  <= wr_data;
        cpu_pkg::REG_Z:  z  <= wr_data;
        cpu_pkg::REG_IR: ir <= wr_data;
        default: ;
      endcase
    end
  end

endmodule

// File: logic/microcode_rom.sv
`timescale 1ns/1ps

module microcode_rom (
  input  cpu_pkg::byte_t         opcode,
  output cpu_pkg::control_word_t control_word
);

  // Immediate operand byte from PC, PC steps past it
  function automatic cpu_pkg::cycle_word_t imm_read(input cpu_pkg::reg_sel_t dst);
    cpu_pkg::cycle_word_t cyc;
    cyc = cpu_pkg::CYCLE_IDLE;
    cyc.addr_src = cpu_pkg::ADDR_PC;
    cyc.idu_op = cpu_pkg::IDU_INC;
    cyc.bus_op = cpu_pkg::BUS_READ;
    cyc.bus_reg = dst;
    return cyc;
  endfunction

  // Single cycle ALU ops run during the fetch of the next opcode
  function automatic cpu_pkg::cycle_word_t fetch_alu(input cpu_pkg::alu_op_t op,
                                                     input cpu_pkg::reg_sel_t src);
    cpu_pkg::cycle_word_t cyc;
    cyc = cpu_pkg::CYCLE_FETCH;
    cyc.alu_op = op;
    cyc.alu_src = src;
    return cyc;
  endfunction

  cpu_pkg::cycle_word_t hl_cycle;
  cpu_pkg::cycle_word_t jump_cycle;

  always_comb begin
    control_word = cpu_pkg::CW_NOP;

    hl_cycle = cpu_pkg::CYCLE_IDLE;
    hl_cycle.addr_src = cpu_pkg::ADDR_HL;
    hl_cycle.bus_reg = cpu_pkg::REG_A;

    jump_cycle = cpu_pkg::CYCLE_IDLE;
    jump_cycle.misc_op = cpu_pkg::MISC_JUMP_WZ;

    case (opcode)
      8'h06, 8'h0E, 8'h26, 8'h2E, 8'h3E: begin
        control_word.num_cycles = 3'd2;
        case (opcode)
          8'h06:   control_word.cycles[0] = imm_read(cpu_pkg::REG_B);
          8'h0E:   control_word.cycles[0] = imm_read(cpu_pkg::REG_C);
          8'h26:   control_word.cycles[0] = imm_read(cpu_pkg::REG_H);
          8'h2E:   control_word.cycles[0] = imm_read(cpu_pkg::REG_L);
          default: control_word.cycles[0] = imm_read(cpu_pkg::REG_A);
        endcase
        control_word.cycles[1] = cpu_pkg::CYCLE_FETCH;
      end
      8'h21: begin
        // Low byte first
        control_word.num_cycles = 3'd3;
        control_word.cycles[0] = imm_read(cpu_pkg::REG_L);
        control_word.cycles[1] = imm_read(cpu_pkg::REG_H);
        control_word.cycles[2] = cpu_pkg::CYCLE_FETCH;
      end
      8'h77, 8'h7E: begin
        hl_cycle.bus_op = (opcode == 8'h77) ? cpu_pkg::BUS_WRITE : cpu_pkg::BUS_READ;
        control_word.num_cycles = 3'd2;
        control_word.cycles[0] = hl_cycle;
        control_word.cycles[1] = cpu_pkg::CYCLE_FETCH;
      end
      8'h80: control_word.cycles[0] = fetch_alu(cpu_pkg::ALU_ADD, cpu_pkg::REG_B);
      8'h90: control_word.cycles[0] = fetch_alu(cpu_pkg::ALU_SUB, cpu_pkg::REG_B);
      8'hA0: control_word.cycles[0] = fetch_alu(cpu_pkg::ALU_AND, cpu_pkg::REG_B);
      8'hAF: control_word.cycles[0] = fetch_alu(cpu_pkg::ALU_XOR, cpu_pkg::REG_A);
      8'h3C: control_word.cycles[0] = fetch_alu(cpu_pkg::ALU_INC, cpu_pkg::REG_A);
      8'hC3, 8'hC2, 8'hCA: begin
        control_word.num_cycles = 3'd4;
        control_word.cycles[0] = imm_read(cpu_pkg::REG_Z);
        control_word.cycles[1] = imm_read(cpu_pkg::REG_W);
        // Conditional forms test the flags once the target is in WZ
        if (opcode != 8'hC3) begin
          control_word.cycles[1].misc_op = cpu_pkg::MISC_COND_CHECK;
          control_word.cycles[1].cond =
              (opcode == 8'hCA) ? cpu_pkg::COND_Z : cpu_pkg::COND_NZ;
        end
        control_word.cycles[2] = jump_cycle;
        control_word.cycles[3] = cpu_pkg::CYCLE_FETCH;
      end
      default: control_word = cpu_pkg::CW_NOP;
    endcase
  end

endmodule

// File: logic/sm83_lite_top.sv
`timescale 1ns/1ps

module sm83_lite_top #(
  // Start address of the first opcode fetch
  parameter cpu_pkg::addr_t RESET_VECTOR = cpu_pkg::RESET_PC
) (
  input  logic           clk,
  input  logic           reset,
  input  cpu_pkg::byte_t rdata,
  output cpu_pkg::addr_t addr,
  output cpu_pkg::byte_t wdata,
  output logic           read_en,
  output logic           write_en,
  output logic           instr_boundary
);

  // Memory lives outside, the core owns the bus
  cpu_core #(
    .RESET_VECTOR (RESET_VECTOR)
  ) core_i (
    .clk            (clk),
    .reset          (reset),
    .rdata          (rdata),
    .addr           (addr),
    .wdata          (wdata),
    .read_en        (read_en),
    .write_en       (write_en),
    .instr_boundary (instr_boundary)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module sm83_lite_tb -f sm83_lite.f \
  -Mdir obj_dir -o sim_sm83_lite
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_sm83_lite)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// File: sm83_lite.f
logic/cpu_pkg.sv
logic/microcode_rom.sv
logic/cpu_regs.sv
logic/cpu_alu.sv
logic/cpu_core.sv
logic/sm83_lite_top.sv
dv/sm83_lite_tb.sv
